// File: vlog.f
+incdir+testbench
common/saturnBusPkg.sv
common/cdHostPkg.sv
common/decodedReqIf.sv
common/accessResultIf.sv
logic/cdHostRegs.sv
saturnBus/busDecode.sv
saturnBus/accessExecute.sv
saturnBus/responseGen.sv
saturnBus/saturnBus.sv
testbench/saturnBusTb.sv

// File: testbench/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef logic [22:0] wordKey;

typedef struct {
	busAddr addr;
	busRegion region;
	logic write;
	busData data;
	busStrb strb;
} memAccess;

typedef struct {
	logic write;
	busData data;
	logic [1:0] resp;
} busResponse;

// expected contents, and what the memory device really holds
busData refMem [wordKey];
busData devMem [wordKey];
memAccess accessQ [$];
busResponse respQ [$];

cdWord refHirq = hirqReset;
cdWord refMask = hirqMaskReset;
cdWord refCr [4] = '{crReset1, crReset2, crReset3, crReset4};

// untouched words, rom included
function automatic busData fillWord(input busAddr a);
	return {a[6:0] ^ 7'h35, a};
endfunction

function automatic busData memWord(input busAddr a);
	return refMem.exists(a[24:2]) ? refMem[a[24:2]] : fillWord({a[24:2], 2'b00});
endfunction

function automatic busData devWord(input wordKey k);
	return devMem.exists(k) ? devMem[k] : fillWord({k, 2'b00});
endfunction

function automatic busData mergeBytes(input busData old, input busData data, input busStrb strb);
	busData merged;
	merged = old;
	for (int b = 0; b < 4; b++) begin
		if (strb[b]) begin
			merged[8*b +: 8] = data[8*b +: 8];
		end
	end
	return merged;
endfunction

function automatic busRegion regionOf(input busAddr a);
	if (a <= 25'h00FFFFF) begin
		return romRegion;
	end else if (a >= 25'h0200000 && a <= 25'h02FFFFF) begin
		return ramLowRegion;
	end else if (a >= 25'h0600000 && a <= 25'h07FFFFF) begin
		return ramHighRegion;
	end else if (a >= 25'h1890000 && a <= 25'h189FFFF) begin
		return cdRegRegion;
	end
	return unmappedRegion;
endfunction

function automatic cdWord cdRead(input cdOffset off);
	case (off)
		offHirq: return refHirq;
		offHirqMask: return refMask;
		offCr1: return refCr[0];
		offCr2: return refCr[1];
		offCr3: return refCr[2];
		offCr4: return refCr[3];
		default: return 16'h0000;
	endcase
endfunction

function automatic void cdWrite(input cdOffset off, input cdWord value);
	case (off)
		offHirq: refHirq = refHirq & value;
		offHirqMask: refMask = value;
		offCr1: refCr[0] = value;
		offCr2: refCr[1] = value;
		offCr3: refCr[2] = value;
		offCr4: refCr[3] = value;
		default: ;
	endcase
endfunction

// async memory on the far side of the chip selects
initial begin : memResponder
	memAccess acc;
	wordKey key;
	int waitLeft;
	logic busy;
	memWaitN = 1'b1;
	memDataIn = '0;
	busy = 1'b0;
	waitLeft = 0;
	forever begin
		@(posedge CLK);
		#1;
		if (romCsN && ramLCsN && ramHCsN) begin
			busy = 1'b0;
			memWaitN = 1'b1;
		end else begin
			if (!busy) begin
				if (accessQ.size() == 0) begin
					$display("memory access at %0t with no request pending", $time);
					abortRun();
				end
				acc = accessQ.pop_front();
				checkBit("romCsN", romCsN, acc.region != romRegion);
				checkBit("ramLCsN", ramLCsN, acc.region != ramLowRegion);
				checkBit("ramHCsN", ramHCsN, acc.region != ramHighRegion);
				checkAddr("memAddr", memAddr, acc.addr);
				checkBit("memRdN", memRdN, acc.write);
				checkStrb("memDqmN", memDqmN, acc.write ? ~acc.strb : 4'h0);
				if (acc.write) begin
					checkData("memDataOut", memDataOut, acc.data);
				end
				busy = 1'b1;
				waitLeft = int'(randBits(memStream, 2));
			end
			key = memAddr[24:2];
			if (waitLeft == 0) begin
				memWaitN = 1'b1;
				if (memRdN) begin
					devMem[key] = mergeBytes(devWord(key), memDataOut, ~memDqmN);
				end else begin
					memDataIn = devWord(key);
				end
			end else begin
				memWaitN = 1'b0;
				waitLeft--;
			end
		end
	end
end

`endif

// File: testbench/saturnBusTb.sv
`timescale 1ns/10ps
`default_nettype none

module saturnBusTb import saturnBusPkg::*; import cdHostPkg::*; ();

	localparam logic [31:0] lfsrSeed = 32'hd5f7f04c;
	localparam int stimStream = 0;
	localparam int ackStream = 1;
	localparam int memStream = 2;

	localparam int romOps = 8;
	localparam int ramOps = 16;
	localparam int cdOps = 12;
	localparam int eventOps = 8;
	localparam int unmapOps = 10;
	localparam int mixOps = 60;
	// three per ram pass plus three sweeps of eight cd reads
	localparam int totalOps = romOps + 3 * ramOps + cdOps + 2 * eventOps + 2
		+ unmapOps + mixOps + 3 * 8;

	localparam cdOffset cdSweep [8] = '{16'h0008, 16'h000C, 16'h0018, 16'h001C,
		16'h0020, 16'h0024, 16'h0010, 16'h8008};

	logic CLK;
	logic RST_N;
	busAddr awAddr;
	logic awValid;
	logic awReady;
	busData wData;
	busStrb wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	busAddr arAddr;
	logic arValid;
	logic arReady;
	busData rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;
	busAddr memAddr;
	busData memDataOut;
	busData memDataIn;
	busStrb memDqmN;
	logic memRdN;
	logic romCsN;
	logic ramLCsN;
	logic ramHCsN;
	logic memWaitN;
	cdWord cdEvent;
	logic cdIrq;

	int errorCount = 0;
	logic [31:0] lfsrState [3] = '{lfsrSeed, lfsrSeed, lfsrSeed};

	saturnBus saturnBus_i (.*);

	`include "tbModel.svh"

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [31:0] randBits(input int stream, input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState[stream] = galoisStep(lfsrState[stream]);
			value = {value[30:0], lfsrState[stream][0]};
		end
		return value;
	endfunction

	function automatic busStrb randStrb();
		return busStrb'(randBits(stimStream, 4));
	endfunction

	task automatic abortRun();
		errorCount++;
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkData(input string name, input busData got, input busData exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkResp(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkIrq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: cdIrq got %b expected %b", $time, got, exp);
			abortRun();
		end
	endtask

	task automatic checkAddr(input string name, input busAddr got, input busAddr exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkStrb(input string name, input busStrb got, input busStrb exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	function automatic busAddr romAddr();
		return busAddr'(randBits(stimStream, 18)) << 2;
	endfunction

	// both ram banks near the start and near the top
	function automatic busAddr ramAddr();
		busAddr base;
		case (randBits(stimStream, 2))
			0: base = 25'h0200000;
			1: base = 25'h02FFFC0;
			2: base = 25'h0600000;
			default: base = 25'h07FFFC0;
		endcase
		return base + (busAddr'(randBits(stimStream, 4)) << 2);
	endfunction

	function automatic busAddr cdAddr();
		return 25'h1890000 | busAddr'(cdSweep[randBits(stimStream, 3)]);
	endfunction

	function automatic busAddr unmappedAddr();
		busAddr base;
		case (randBits(stimStream, 2))
			0: base = 25'h0100000;
			1: base = 25'h0300000;
			2: base = 25'h0800000;
			default: base = 25'h18A0000;
		endcase
		return base + (busAddr'(randBits(stimStream, 4)) << 2);
	endfunction

	task automatic issueWrite(input busAddr addr, input busData data, input busStrb strb);
		logic taken;
		awAddr = addr;
		wData = data;
		wStrb = strb;
		awValid = 1'b1;
		wValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge CLK);
			taken = awReady;
			checkBit("wReady", wReady, awReady);
			@(posedge CLK);
			#1;
		end
		awValid = 1'b0;
		wValid = 1'b0;
	endtask

	task automatic issueRead(input busAddr addr);
		logic taken;
		arAddr = addr;
		arValid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			@(negedge CLK);
			taken = arReady;
			@(posedge CLK);
			#1;
		end
		arValid = 1'b0;
	endtask

	task automatic doWrite(input busAddr addr, input busData data, input busStrb strb);
		busResponse exp;
		busRegion region;
		region = regionOf(addr);
		exp.write = 1'b1;
		exp.data = '0;
		exp.resp = respOkay;
		if (region == cdRegRegion) begin
			if (strb[1:0] != 2'b00) begin
				cdWrite(addr[15:0], data[15:0]);
			end
		end else if (region == unmappedRegion) begin
			exp.resp = respDecErr;
		end else begin
			accessQ.push_back(memAccess'{addr, region, 1'b1, data, strb});
			refMem[addr[24:2]] = mergeBytes(memWord(addr), data, strb);
		end
		respQ.push_back(exp);
		issueWrite(addr, data, strb);
	endtask

	task automatic doRead(input busAddr addr);
		busResponse exp;
		busRegion region;
		region = regionOf(addr);
		exp.write = 1'b0;
		exp.data = '0;
		exp.resp = respOkay;
		if (region == cdRegRegion) begin
			exp.data = {16'h0000, cdRead(addr[15:0])};
		end else if (region == unmappedRegion) begin
			exp.resp = respDecErr;
		end else begin
			exp.data = memWord(addr);
			accessQ.push_back(memAccess'{addr, region, 1'b0, 32'h0, 4'h0});
		end
		respQ.push_back(exp);
		issueRead(addr);
	endtask

	task automatic randomOp();
		logic wantWrite;
		busAddr addr;
		wantWrite = randBits(stimStream, 1) != 0;
		case (randBits(stimStream, 2))
			0: addr = romAddr();
			1: addr = ramAddr();
			2: addr = cdAddr();
			default: addr = unmappedAddr();
		endcase
		if (wantWrite && regionOf(addr) != romRegion) begin
			doWrite(addr, randBits(stimStream, 32), randStrb());
		end else begin
			doRead(addr);
		end
	endtask

	task automatic readAllCd();
		foreach (cdSweep[i]) begin
			doRead(25'h1890000 | busAddr'(cdSweep[i]));
		end
	endtask

	task automatic drain();
		while (respQ.size() != 0) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// held responses must not move under random back-pressure
	initial begin : responseCollector
		busResponse exp;
		busData heldData;
		logic [1:0] heldResp;
		logic holdB;
		logic holdR;
		bReady = 1'b0;
		rReady = 1'b0;
		holdB = 1'b0;
		holdR = 1'b0;
		@(posedge RST_N);
		forever begin
			@(posedge CLK);
			#1;
			if (holdB) begin
				checkBit("bValid", bValid, 1'b1);
				checkResp("bResp", bResp, heldResp);
			end
			if (holdR) begin
				checkBit("rValid", rValid, 1'b1);
				checkData("rData", rData, heldData);
				checkResp("rResp", rResp, heldResp);
			end
			bReady = randBits(ackStream, 1) != 0;
			rReady = randBits(ackStream, 1) != 0;
			holdB = bValid && !bReady;
			holdR = rValid && !rReady;
			heldData = rData;
			heldResp = bValid ? bResp : rResp;
			if ((bValid && bReady) || (rValid && rReady)) begin
				if (respQ.size() == 0) begin
					$display("response at %0t with no transaction outstanding", $time);
					abortRun();
				end
				exp = respQ.pop_front();
				checkBit("bValid", bValid, exp.write);
				if (exp.write) begin
					checkResp("bResp", bResp, exp.resp);
				end else begin
					checkResp("rResp", rResp, exp.resp);
					checkData("rData", rData, exp.data);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (totalOps * 200) @(posedge CLK);
		$display("Timeout: run still busy after %0d cycles", totalOps * 200);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin : stimulus
		busAddr addr;
		cdWord pulse;
		logic irqBefore;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		cdEvent = '0;
		RST_N = 1'b0;
		repeat (5) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		checkIrq(cdIrq, 1'b0);
		checkBit("romCsN", romCsN, 1'b1);
		checkBit("ramLCsN", ramLCsN, 1'b1);
		checkBit("ramHCsN", ramHCsN, 1'b1);
		checkBit("memRdN", memRdN, 1'b1);
		checkStrb("memDqmN", memDqmN, 4'hF);
		checkBit("awReady", awReady, 1'b0);
		checkBit("wReady", wReady, 1'b0);
		checkBit("arReady", arReady, 1'b0);
		checkBit("bValid", bValid, 1'b0);
		checkBit("rValid", rValid, 1'b0);

		repeat (romOps) doRead(romAddr());
		drain();

		// write and read back plus one read elsewhere
		repeat (ramOps) begin
			addr = ramAddr();
			doWrite(addr, randBits(stimStream, 32), randStrb());
			doRead(addr);
			doRead(ramAddr());
		end
		drain();

		readAllCd();
		repeat (cdOps) begin
			doWrite(cdAddr(), randBits(stimStream, 32), randStrb());
			drain();
			checkIrq(cdIrq, |(refHirq & refMask));
		end
		readAllCd();
		drain();

		// clear hirq so that pulses show up
		doWrite(25'h1890008, 32'h0, 4'h3);
		doWrite(25'h189000C, randBits(stimStream, 32), 4'h3);
		drain();
		repeat (eventOps) begin
			pulse = cdWord'(randBits(stimStream, 16) & randBits(stimStream, 16));
			irqBefore = |(refHirq & refMask);
			cdEvent = pulse;
			refHirq = refHirq | pulse;
			@(posedge CLK);
			#1;
			cdEvent = '0;
			checkIrq(cdIrq, irqBefore);
			@(posedge CLK);
			#1;
			checkIrq(cdIrq, |(refHirq & refMask));
			doRead(25'h1890008);
			doWrite(25'h1890008, randBits(stimStream, 32), 4'h3);
			drain();
			checkIrq(cdIrq, |(refHirq & refMask));
		end

		repeat (unmapOps) begin
			if (randBits(stimStream, 1) != 0) begin
				doWrite(unmappedAddr(), randBits(stimStream, 32), randStrb());
			end else begin
				doRead(unmappedAddr());
			end
		end
		readAllCd();
		drain();

		repeat (mixOps) randomOp();
		drain();
		checkIrq(cdIrq, |(refHirq & refMask));
		if (accessQ.size() != 0) begin
			$display("%0d expected memory accesses never appeared", accessQ.size());
			abortRun();
		end

		if (errorCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "errors were recorded");
		end
	end

endmodule

`default_nettype wire

// File: saturnBus/saturnBus.sv
`timescale 1ns/10ps
`default_nettype none

module saturnBus import saturnBusPkg::*; import cdHostPkg::*; #(
	parameter int memWaitLimit = 255
) (
	input wire logic CLK,
	input wire logic RST_N,

	// axi4-lite slave
	input wire busAddr awAddr,
	input wire logic awValid,
	output logic awReady,
	input wire busData wData,
	input wire busStrb wStrb,
	input wire logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input wire logic bReady,
	input wire busAddr arAddr,
	input wire logic arValid,
	output logic arReady,
	output busData rData,
	output logic [1:0] rResp,
	output logic rValid,
	input wire logic rReady,

	// external async memory
	output busAddr memAddr,
	output busData memDataOut,
	input wire busData memDataIn,
	output busStrb memDqmN,
	output logic memRdN,
	output logic romCsN,
	output logic ramLCsN,
	output logic ramHCsN,
	input wire logic memWaitN,

	// cd block
	input wire cdWord cdEvent,
	output logic cdIrq
);

	decodedReqIf reqBus ();
	accessResultIf resBus ();

	busDecode busDecode_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.awAddr(awAddr),
		.awValid(awValid),
		.awReady(awReady),
		.wData(wData),
		.wStrb(wStrb),
		.wValid(wValid),
		.wReady(wReady),
		.arAddr(arAddr),
		.arValid(arValid),
		.arReady(arReady),
		.req(reqBus.master)
	);

	accessExecute #(
		.memWaitLimit(memWaitLimit)
	) accessExecute_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.req(reqBus.slave),
		.res(resBus.master),
		.memAddr(memAddr),
		.memDataOut(memDataOut),
		.memDataIn(memDataIn),
		.memDqmN(memDqmN),
		.memRdN(memRdN),
		.romCsN(romCsN),
		.ramLCsN(ramLCsN),
		.ramHCsN(ramHCsN),
		.memWaitN(memWaitN),
		.cdEvent(cdEvent),
		.cdIrq(cdIrq)
	);

	responseGen responseGen_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.res(resBus.slave),
		.bResp(bResp),
		.bValid(bValid),
		.bReady(bReady),
		.rData(rData),
		.rResp(rResp),
		.rValid(rValid),
		.rReady(rReady)
	);

endmodule

`default_nettype wire

// File: saturnBus/responseGen.sv
`timescale 1ns/10ps
`default_nettype none

module responseGen import saturnBusPkg::*; (
	input wire logic CLK,
	input wire logic RST_N,
	accessResultIf.slave res,
	output logic [1:0] bResp,
	output logic bValid,
	input wire logic bReady,
	output busData rData,
	output logic [1:0] rResp,
	output logic rValid,
	input wire logic rReady
);

	logic take;

	// free once the held response leaves on this edge
	assign res.ready = (!bValid || bReady) && (!rValid || rReady);
	assign take = res.valid && res.ready;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bValid <= 1'b0;
			rValid <= 1'b0;
		end else if (take) begin
			bValid <= res.write;
			rValid <= !res.write;
		end else begin
			if (bReady) begin
				bValid <= 1'b0;
			end
			if (rReady) begin
				rValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (take && res.write) begin
			bResp <= res.resp;
		end
		if (take && !res.write) begin
			rData <= res.data;
			rResp <= res.resp;
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp));

endmodule

`default_nettype wire

// File: saturnBus/accessExecute.sv
`timescale 1ns/10ps
`default_nettype none

module accessExecute import saturnBusPkg::*; import cdHostPkg::*; #(
	parameter int memWaitLimit = 255
) (
	input wire logic CLK,
	input wire logic RST_N,
	decodedReqIf.slave req,
	accessResultIf.master res,
	output busAddr memAddr,
	output busData memDataOut,
	input wire busData memDataIn,
	output busStrb memDqmN,
	output logic memRdN,
	output logic romCsN,
	output logic ramLCsN,
	output logic ramHCsN,
	input wire logic memWaitN,
	input wire cdWord cdEvent,
	output logic cdIrq
);

	localparam int waitWidth = $clog2(memWaitLimit + 2);

	typedef enum logic [1:0] {execIdle, execMem, execQuick} execState;

	execState state;
	busRegion curRegion;
	busAddr curAddr;
	busData curData;
	busStrb curStrb;
	logic curWrite;
	logic [waitWidth-1:0] waitCount;
	logic take;
	logic isMem;
	logic memDone;
	logic regWrite;
	cdWord regReadData;

	assign req.ready = state == execIdle && (!res.valid || res.ready);
	assign take = req.valid && req.ready;
	assign isMem = req.region inside {romRegion, ramLowRegion, ramHighRegion};
	assign memDone = state == execMem && memWaitN;
	// only the low half reaches the cd registers
	assign regWrite = state == execQuick && curRegion == cdRegRegion
		&& curWrite && |curStrb[1:0];
	assign memAddr = curAddr;
	assign memDataOut = curData;

	cdHostRegs cdHostRegs_i (
		.CLK(CLK),
		.RST_N(RST_N),
		.regOffset(curAddr[15:0]),
		.regWriteData(curData[15:0]),
		.regWrite(regWrite),
		.regReadData(regReadData),
		.cdEvent(cdEvent),
		.cdIrq(cdIrq)
	);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= execIdle;
			res.valid <= 1'b0;
			romCsN <= 1'b1;
			ramLCsN <= 1'b1;
			ramHCsN <= 1'b1;
			memRdN <= 1'b1;
			memDqmN <= '1;
			waitCount <= '0;
		end else begin
			if (res.valid && res.ready) begin
				res.valid <= 1'b0;
			end
			case (state)
				execIdle: begin
					if (take && isMem) begin
						state <= execMem;
						romCsN <= req.region != romRegion;
						ramLCsN <= req.region != ramLowRegion;
						ramHCsN <= req.region != ramHighRegion;
						memRdN <= req.write;
						memDqmN <= req.write ? ~req.strb : '0;
						waitCount <= '0;
					end else if (take) begin
						state <= execQuick;
					end
				end
				execMem: begin
					if (memWaitN) begin
						state <= execIdle;
						res.valid <= 1'b1;
						romCsN <= 1'b1;
						ramLCsN <= 1'b1;
						ramHCsN <= 1'b1;
						memRdN <= 1'b1;
						memDqmN <= '1;
					end else if (!(&waitCount)) begin
						waitCount <= waitCount + 1'b1;
					end
				end
				execQuick: begin
					state <= execIdle;
					res.valid <= 1'b1;
				end
				default: state <= execIdle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			curRegion <= req.region;
			curAddr <= req.addr;
			curData <= req.data;
			curStrb <= req.strb;
			curWrite <= req.write;
		end
		if (memDone) begin
			res.data <= memDataIn;
			res.resp <= respOkay;
			res.write <= curWrite;
		end else if (state == execQuick) begin
			res.data <= curRegion == cdRegRegion ? {16'h0000, regReadData} : '0;
			res.resp <= curRegion == cdRegRegion ? respOkay : respDecErr;
			res.write <= curWrite;
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({~romCsN, ~ramLCsN, ~ramHCsN}));

	// memory must not stretch past the wait budget
	assert property (@(posedge CLK) disable iff (!RST_N)
		state == execMem |-> waitCount < memWaitLimit);

endmodule

`default_nettype wire

// File: saturnBus/busDecode.sv
`timescale 1ns/10ps
`default_nettype none

module busDecode import saturnBusPkg::*; (
	input wire logic CLK,
	input wire logic RST_N,
	input wire busAddr awAddr,
	input wire logic awValid,
	output logic awReady,
	input wire busData wData,
	input wire busStrb wStrb,
	input wire logic wValid,
	output logic wReady,
	input wire busAddr arAddr,
	input wire logic arValid,
	output logic arReady,
	decodedReqIf.master req
);

	logic preferRead;
	logic canAccept;
	logic writePending;
	logic pickRead;
	logic pickWrite;
	logic accept;
	busAddr pickAddr;

	function automatic busRegion decodeRegion(busAddr addr);
		if (addr >= romBase && addr <= romLimit) begin
			return romRegion;
		end else if (addr >= ramLowBase && addr <= ramLowLimit) begin
			return ramLowRegion;
		end else if (addr >= ramHighBase && addr <= ramHighLimit) begin
			return ramHighRegion;
		end else if (addr >= cdRegBase && addr <= cdRegLimit) begin
			return cdRegRegion;
		end
		return unmappedRegion;
	endfunction

	// register free now or draining on this edge
	assign canAccept = !req.valid || req.ready;
	assign writePending = awValid && wValid;
	assign pickRead = arValid && (preferRead || !writePending);
	assign pickWrite = writePending && !pickRead;

	assign arReady = canAccept && pickRead;
	assign awReady = canAccept && pickWrite;
	assign wReady = canAccept && pickWrite;
	assign accept = arReady || awReady;
	assign pickAddr = pickRead ? arAddr : awAddr;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			req.valid <= 1'b0;
			preferRead <= 1'b1;
		end else begin
			if (accept) begin
				req.valid <= 1'b1;
			end else if (req.ready) begin
				req.valid <= 1'b0;
			end
			// flip only when both sides were competing
			if (accept && arValid && writePending) begin
				preferRead <= !pickRead;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			req.addr <= pickAddr;
			req.region <= decodeRegion(pickAddr);
			req.data <= wData;
			req.strb <= wStrb;
			req.write <= pickWrite;
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N)
		req.valid && !req.ready |=> req.valid
			&& $stable({req.addr, req.region, req.data, req.strb, req.write}));

endmodule

`default_nettype wire

// File: logic/cdHostRegs.sv
`timescale 1ns/10ps
`default_nettype none

module cdHostRegs import cdHostPkg::*; (
	input wire logic CLK,
	input wire logic RST_N,
	input wire cdOffset regOffset,
	input wire cdWord regWriteData,
	input wire logic regWrite,
	output cdWord regReadData,
	input wire cdWord cdEvent,
	output logic cdIrq
);

	cdWord hirq;
	cdWord hirqMask;
	cdWord cr [4];
	logic hirqWrite;
	cdWord hirqKept;

	// host clears by writing zeros, ones leave bits alone
	assign hirqWrite = regWrite && regOffset == offHirq;
	assign hirqKept = hirqWrite ? (hirq & regWriteData) : hirq;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hirq <= hirqReset;
			hirqMask <= hirqMaskReset;
			cr[0] <= crReset1;
			cr[1] <= crReset2;
			cr[2] <= crReset3;
			cr[3] <= crReset4;
			cdIrq <= 1'b0;
		end else begin
			// new events win over a clear in the same cycle
			hirq <= hirqKept | cdEvent;
			cdIrq <= |(hirq & hirqMask);
			if (regWrite) begin
				case (regOffset)
					offHirqMask: hirqMask <= regWriteData;
					offCr1: cr[0] <= regWriteData;
					offCr2: cr[1] <= regWriteData;
					offCr3: cr[2] <= regWriteData;
					offCr4: cr[3] <= regWriteData;
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (regOffset)
			offHirq: regReadData = hirq;
			offHirqMask: regReadData = hirqMask;
			offCr1: regReadData = cr[0];
			offCr2: regReadData = cr[1];
			offCr3: regReadData = cr[2];
			offCr4: regReadData = cr[3];
			default: regReadData = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: common/accessResultIf.sv
`timescale 1ns/10ps
`default_nettype none

// finished access from execute stage to response stage
interface accessResultIf import saturnBusPkg::*; ();

	logic valid;
	logic ready;
	logic write;
	busData data;
	logic [1:0] resp;

	modport master (
		output valid,
		input ready,
		output write,
		output data,
		output resp
	);

	modport slave (
		input valid,
		output ready,
		input write,
		input data,
		input resp
	);

endinterface

`default_nettype wire

// File: common/decodedReqIf.sv
`timescale 1ns/10ps
`default_nettype none

// decoded request from decode stage to execute stage
interface decodedReqIf import saturnBusPkg::*; ();

	logic valid;
	logic ready;
	busRegion region;
	busAddr addr;
	busData data;
	busStrb strb;
	logic write;

	modport master (
		output valid,
		input ready,
		output region,
		output addr,
		output data,
		output strb,
		output write
	);

	modport slave (
		input valid,
		output ready,
		input region,
		input addr,
		input data,
		input strb,
		input write
	);

endinterface

`default_nettype wire

// File: common/cdHostPkg.sv
`default_nettype none

package cdHostPkg;

	typedef logic [15:0] cdWord;
	typedef logic [15:0] cdOffset;

	// register offsets within the host window
	localparam cdOffset offHirq = 16'h0008;
	localparam cdOffset offHirqMask = 16'h000C;
	localparam cdOffset offCr1 = 16'h0018;
	localparam cdOffset offCr2 = 16'h001C;
	localparam cdOffset offCr3 = 16'h0020;
	localparam cdOffset offCr4 = 16'h0024;

	// all interrupt sources pending out of reset
	localparam cdWord hirqReset = 16'hFFFF;
	localparam cdWord hirqMaskReset = 16'h0000;

	// CR1..CR4 spell "CDBLOCK" after reset
	localparam cdWord crReset1 = 16'h0043;
	localparam cdWord crReset2 = 16'h4442;
	localparam cdWord crReset3 = 16'h4C4F;
	localparam cdWord crReset4 = 16'h434B;

endpackage

`default_nettype wire

// File: common/saturnBusPkg.sv
`default_nettype none

package saturnBusPkg;

	// bus widths
	localparam int addrWidth = 25;
	localparam int dataWidth = 32;
	localparam int strbWidth = 4;

	typedef logic [addrWidth-1:0] busAddr;
	typedef logic [dataWidth-1:0] busData;
	typedef logic [strbWidth-1:0] busStrb;

	typedef enum logic [2:0] {
		romRegion,
		ramLowRegion,
		ramHighRegion,
		cdRegRegion,
		unmappedRegion
	} busRegion;

	// boot rom
	localparam busAddr romBase = 25'h0000000;
	localparam busAddr romLimit = 25'h00FFFFF;

	// work ram, low and high banks
	localparam busAddr ramLowBase = 25'h0200000;
	localparam busAddr ramLowLimit = 25'h02FFFFF;
	localparam busAddr ramHighBase = 25'h0600000;
	localparam busAddr ramHighLimit = 25'h07FFFFF;

	// cd block host window
	localparam busAddr cdRegBase = 25'h1890000;
	localparam busAddr cdRegLimit = 25'h189FFFF;

	// axi response codes
	localparam logic [1:0] respOkay = 2'd0;
	localparam logic [1:0] respDecErr = 2'd3;

endpackage

`default_nettype wire
